// File: sim/cache_stim.txt
# op test addr data hit expected_data, all hex except test
# IDLE and STALL use the data column as a cycle count
RD 1 00002940 0 0 0
RD 1 00004640 0 0 0
WR 2 00002940 1111111111111111 0 0
WR 2 00002958 3333333333333333 0 0
WR 2 00002978 7777777777777777 0 0
RD 2 00002940 0 1 1111111111111111
RD 2 00002958 0 1 3333333333333333
RD 2 00002978 0 1 7777777777777777
WR 2 00002958 33330000aaaa0003 0 0
RD 2 00002958 0 1 33330000aaaa0003
RD 2 00002940 0 1 1111111111111111
RD 2 00002978 0 1 7777777777777777
WR 3 00004640 0000000000000011 0 0
WR 3 00004a40 0000000000000012 0 0
WR 3 00004e40 0000000000000013 0 0
WR 3 00005240 0000000000000014 0 0
WR 3 00005640 0000000000000015 0 0
RD 3 00004640 0 1 0000000000000011
RD 3 00004a40 0 1 0000000000000012
RD 3 00004e40 0 1 0000000000000013
RD 3 00005640 0 1 0000000000000015
RD 3 00005240 0 0 0
IDLE 4 0 c8 0 0
RD 4 00004a40 0 1 0000000000000012
WR 4 00005a40 0000000000000016 0 0
RD 4 00004640 0 0 0
RD 4 00005a40 0 1 0000000000000016
RD 4 00004a40 0 1 0000000000000012
RD 4 00004e40 0 1 0000000000000013
RD 4 00005640 0 1 0000000000000015
STALL 5 00002940 3 1 1111111111111111
WRRD 5 00002978 7700000000000077 1 7700000000000077
RD 5 00002978 0 1 7700000000000077
FLUSH 6 0 0 0 0
RD 6 00002940 0 0 0
RD 6 00005640 0 0 0

// File: tb.f
src/cache_pkg.sv
src/line_ram.sv
src/data_array.sv
src/read_stage.sv
src/tag_store.sv
src/l1_cache.sv
sim/l1_cache_sva.sv
sim/tb_l1_cache.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_l1_cache -f tb.f -o sim_l1_cache

out=$(./obj_dir/sim_l1_cache)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

// File: sim/tb_l1_cache.sv
// Testbench for l1_cache with stim-file driver, tag/status model, checks and watchdog
`timescale 1ns/100ps

module tb_l1_cache;

	logic                   iCLOCK;
	logic                   inRESET;
	logic                   flush;
	logic                   rd_req;
	cache_pkg::cache_addr_t rd_addr;
	logic                   rd_stall;
	logic                   wr_req;
	cache_pkg::wr_req_t     wr;
	logic                   rd_busy;
	logic                   rd_valid;
	logic                   rd_hit;
	cache_pkg::word_t       rd_data;

	logic [63:0] s_op   [64];
	int          s_test [64];
	logic [31:0] s_addr [64];
	logic [63:0] s_data [64];
	logic        s_hit  [64];
	logic [63:0] s_exp  [64];
	int          n_ops;
	bit          loaded;
	int          checks, errors, t_checks, t_errors;

	logic [21:0] m_tag [4][16];	// Reference tags and statuses
	logic [1:0]  m_st  [4][16];
	logic [5:0]  m_timer;

	l1_cache #(.AGE_W(6)) dut_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flush(flush), .rd_req(rd_req),
		.rd_addr(rd_addr), .rd_stall(rd_stall), .wr_req(wr_req), .wr(wr),
		.rd_busy(rd_busy), .rd_valid(rd_valid), .rd_hit(rd_hit), .rd_data(rd_data)
	);

	always #20 iCLOCK = ~iCLOCK;

	task automatic load_stim();
		int          fd, r;
		logic [63:0] tok;
		logic [3:0]  h;
		logic [8*200-1:0] rest;
		fd = $fopen("sim/cache_stim.txt", "r");
		n_ops = 0;
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			return;
		end
		while (!$feof(fd) && n_ops < 64) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1) break;
			if (tok == "#") begin
				r = $fgets(rest, fd);	// Rest of a comment line
				continue;
			end
			s_op[n_ops] = tok;
			r = $fscanf(fd, "%d %h %h %h %h", s_test[n_ops], s_addr[n_ops],
				s_data[n_ops], h, s_exp[n_ops]);
			s_hit[n_ops] = h[0];
			n_ops++;
		end
		$fclose(fd);
	endtask

	function automatic logic model_lookup(input logic [31:0] a, output logic [1:0] way);
		logic hit;
		hit = 1'b0;
		way = 2'd0;
		for (int w = 3; w >= 0; w--) begin
			if (m_st[w][a[9:6]] != 2'd0 && m_tag[w][a[9:6]] == a[31:10]) begin
				hit = 1'b1;
				way = 2'(w);
			end
		end
		return hit;
	endfunction

	// Matching line, else oldest below 3 with lower way first, else way 3
	function automatic logic [1:0] model_victim(input logic [31:0] a);
		logic [1:0] way, low;
		if (model_lookup(a, way)) return way;
		low = 2'd3;
		way = 2'd3;
		for (int w = 0; w < 4; w++) begin
			if (m_st[w][a[9:6]] < low) begin
				low = m_st[w][a[9:6]];
				way = 2'(w);
			end
		end
		return way;
	endfunction

	// Applies one clock edge to the model with the inputs seen at that edge
	task automatic model_edge();
		logic acc, mhit, tick;
		logic [1:0] mway, wway;
		acc  = rd_req && !rd_stall && !(wr_req && rd_addr[31:3] == wr.addr[31:3]);
		mhit = model_lookup(rd_addr, mway);
		wway = model_victim(wr.addr);
		tick = (m_timer == 6'h3f) && !rd_stall && !wr_req;
		if (!rd_stall) m_timer++;
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < 16; s++) begin
				if (flush) m_st[w][s] = 2'd0;
				else if (wr_req && wway == 2'(w) && wr.addr.index == 4'(s)) m_st[w][s] = 2'd3;
				else if (acc && mhit && mway == 2'(w) && rd_addr.index == 4'(s))
					m_st[w][s] = 2'd3;
				else if (tick && m_st[w][s] >= 2'd2) m_st[w][s] = m_st[w][s] - 2'd1;
			end
		end
		if (wr_req && !flush) m_tag[wway][wr.addr.index] = wr.addr.tag;
	endtask

	task automatic next_cycle();
		@(posedge iCLOCK);
		model_edge();
		#2;
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		t_checks++;
		if (got !== exp) begin
			$display("ERR %0t %s exp %h got %h", $time, name, exp, got);
			t_errors++;
		end
	endtask

	task automatic check_model(input logic exp_hit);
		logic [1:0] way;
		t_checks++;
		if (model_lookup(rd_addr, way) !== exp_hit) begin
			$display("Model and stimulus file disagree on the hit for address %h", rd_addr);
			t_errors++;
		end
	endtask

	task automatic check_result(input logic exp_hit, input logic [63:0] exp_data);
		@(negedge iCLOCK);
		check_val("rd_valid", 64'(rd_valid), 64'd1);
		check_val("rd_hit", 64'(rd_hit), 64'(exp_hit));
		check_val("rd_data", rd_data, exp_data);
		next_cycle();
	endtask

	// Issues the read and returns after the accepting edge
	task automatic start_read(input logic [31:0] a, input logic exp_hit);
		rd_req  = 1'b1;
		rd_addr = a;
		check_model(exp_hit);
		@(negedge iCLOCK);
		if (rd_busy) begin
			$display("Read of %h was not accepted at %0t", a, $time);
			t_errors++;
		end
		next_cycle();
		rd_req = 1'b0;
	endtask

	task automatic run_op(input int i);
		case (s_op[i])
			"WR": begin
				wr_req    = 1'b1;
				wr.addr   = s_addr[i];
				wr.data   = s_data[i];
				next_cycle();
				wr_req = 1'b0;
			end
			"RD": begin
				start_read(s_addr[i], s_hit[i]);
				check_result(s_hit[i], s_exp[i]);
			end
			"STALL": begin
				start_read(s_addr[i], s_hit[i]);
				rd_stall = 1'b1;
				repeat (int'(s_data[i])) begin
					@(negedge iCLOCK);
					check_val("rd_valid", 64'(rd_valid), 64'd0);
					check_val("rd_busy", 64'(rd_busy), 64'd1);	// Requests held off downstream
					next_cycle();
				end
				rd_stall = 1'b0;
				check_result(s_hit[i], s_exp[i]);
			end
			"WRRD": begin
				wr_req  = 1'b1;
				wr.addr = s_addr[i];
				wr.data = s_data[i];
				rd_req  = 1'b1;
				rd_addr = s_addr[i];
				@(negedge iCLOCK);
				check_val("rd_busy", 64'(rd_busy), 64'd1);	// Same word on both sides
				next_cycle();
				wr_req = 1'b0;
				start_read(s_addr[i], s_hit[i]);
				check_result(s_hit[i], s_exp[i]);
			end
			"FLUSH": begin
				flush   = 1'b1;
				rd_req  = 1'b1;	// Read in the flush cycle gives no result
				rd_addr = s_addr[i];
				next_cycle();
				flush  = 1'b0;
				rd_req = 1'b0;
				@(negedge iCLOCK);
				check_val("rd_valid", 64'(rd_valid), 64'd0);
				next_cycle();
			end
			"IDLE": repeat (int'(s_data[i])) next_cycle();
			default: begin
				$display("Unknown operation in stimulus line %0d", i);
				t_errors++;
			end
		endcase
	endtask

	task automatic report_test(input int t);
		$display("test %0d done: %0d checks, %0d errors", t, t_checks, t_errors);
		checks   += t_checks;
		errors   += t_errors;
		t_checks = 0;
		t_errors = 0;
	endtask

	initial begin
		wait (loaded);
		repeat (n_ops * 8 + 400) @(posedge iCLOCK);
		$display("Timeout: the stimulus did not finish in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		int seed, cur;
		seed     = $urandom(13);
		iCLOCK   = 1'b0;
		inRESET  = 1'b0;
		flush    = 1'b0;
		rd_req   = 1'b0;
		rd_addr  = '0;
		rd_stall = 1'b0;
		wr_req   = 1'b0;
		wr       = '0;
		m_timer  = '0;
		checks   = 0;
		errors   = 0;
		t_checks = 0;
		t_errors = 0;
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < 16; s++) begin
				m_st[w][s]  = 2'd0;
				m_tag[w][s] = '0;
			end
		end
		load_stim();
		loaded = 1'b1;
		repeat (10) @(posedge iCLOCK);
		#2 inRESET = 1'b1;
		cur = (n_ops > 0) ? s_test[0] : 0;
		if (n_ops == 0) errors++;
		for (int i = 0; i < n_ops; i++) begin
			if (s_test[i] != cur) begin
				report_test(cur);
				cur = s_test[i];
			end
			if (s_op[i] != "WR") repeat ($urandom % 4) next_cycle();	// Writes stay back to back
			run_op(i);
		end
		report_test(cur);
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: sim/l1_cache_sva.sv
// Concurrent assertions on the read handshake and flush, bound into l1_cache
`timescale 1ns/100ps

module l1_cache_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_stall,
	input logic rd_valid,
	input logic rd_hit
);

	// Result withheld while downstream stalls
	valid_not_stalled: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(rd_valid && rd_stall))
		else $error("rd_valid high while rd_stall high");

	hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid)
		else $error("rd_hit high without rd_valid");

	flush_drops_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		flush |=> !rd_valid)
		else $error("rd_valid high on the edge after flush");

endmodule

bind l1_cache l1_cache_sva sva_i (
	.iCLOCK   (iCLOCK),
	.inRESET  (inRESET),
	.flush    (flush),
	.rd_stall (rd_stall),
	.rd_valid (rd_valid),
	.rd_hit   (rd_hit)
);

// File: src/l1_cache.sv
// Top level of the 4-way L1 data cache with read/write conflict stall
`timescale 1ns/100ps

module l1_cache #(
	parameter int AGE_W = 16
) (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   flush,
	input  logic                   rd_req,
	input  cache_pkg::cache_addr_t rd_addr,
	input  logic                   rd_stall,
	input  logic                   wr_req,
	input  cache_pkg::wr_req_t     wr,
	output logic                   rd_busy,
	output logic                   rd_valid,
	output logic                   rd_hit,
	output cache_pkg::word_t       rd_data
);

	cache_pkg::lookup_t   lookup;
	cache_pkg::way_t      wr_way;
	cache_pkg::way_t      sel_way;
	cache_pkg::word_idx_t sel_word;
	cache_pkg::word_t     word;
	logic                 same_line;
	logic                 rd_accept;

	// Same 64-bit word on both sides, byte offset ignored
	assign same_line = {rd_addr.tag, rd_addr.index, rd_addr.word}
		== {wr.addr.tag, wr.addr.index, wr.addr.word};

	assign rd_busy   = rd_stall || (rd_req && wr_req && same_line);
	assign rd_accept = rd_req && !rd_busy;

	tag_store #(
		.AGE_W (AGE_W)
	) tag_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.rd_addr   (rd_addr),
		.rd_accept (rd_accept),
		.rd_stall  (rd_stall),
		.wr_req    (wr_req),
		.wr        (wr),
		.lookup    (lookup),
		.wr_way    (wr_way)
	);

	data_array data_i (
		.iCLOCK   (iCLOCK),
		.wr_req   (wr_req),
		.wr       (wr),
		.wr_way   (wr_way),
		.rd_load  (!rd_stall),	// Loads together with the read stage
		.rd_set   (rd_addr.index),
		.sel_way  (sel_way),
		.sel_word (sel_word),
		.word     (word)
	);

	read_stage read_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.rd_stall  (rd_stall),
		.rd_accept (rd_accept),
		.lookup    (lookup),
		.rd_word   (rd_addr.word),
		.word      (word),
		.sel_way   (sel_way),
		.sel_word  (sel_word),
		.rd_valid  (rd_valid),
		.rd_hit    (rd_hit),
		.rd_data   (rd_data)
	);

endmodule

// File: src/tag_store.sv
// Tag and status arrays, hit check, victim choice, recency update and aging timer
`timescale 1ns/100ps

module tag_store #(
	parameter int AGE_W = 16
) (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   flush,
	input  cache_pkg::cache_addr_t rd_addr,
	input  logic                   rd_accept,
	input  logic                   rd_stall,
	input  logic                   wr_req,
	input  cache_pkg::wr_req_t     wr,
	output cache_pkg::lookup_t     lookup,
	output cache_pkg::way_t        wr_way
);

	cache_pkg::tag_t    tags   [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
	cache_pkg::status_t status [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

	logic [AGE_W-1:0]               age_timer;
	logic                           age_tick;
	logic                           rd_refresh;
	logic [cache_pkg::NUM_WAYS-1:0] rd_match;	// Valid tag match per way, read side
	logic [cache_pkg::NUM_WAYS-1:0] wr_match;	// Same for the write address
	cache_pkg::way_t                victim_way;

	always_comb begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			rd_match[w] = (status[w][rd_addr.index] != cache_pkg::STATUS_INVALID)
				&& (tags[w][rd_addr.index] == rd_addr.tag);
			wr_match[w] = (status[w][wr.addr.index] != cache_pkg::STATUS_INVALID)
				&& (tags[w][wr.addr.index] == wr.addr.tag);
		end
	end

	// Lowest matching way wins
	always_comb begin
		lookup.hit = |rd_match;
		lookup.way = '0;
		for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
			if (rd_match[w]) begin
				lookup.way = cache_pkg::way_t'(w);
			end
		end
	end

	// Oldest line below status 3, lower way on a tie, way 3 if the set is all newest
	always_comb begin
		cache_pkg::status_t lowest;
		lowest     = cache_pkg::STATUS_NEWEST;
		victim_way = cache_pkg::way_t'(cache_pkg::NUM_WAYS - 1);
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (status[w][wr.addr.index] < lowest) begin
				lowest     = status[w][wr.addr.index];
				victim_way = cache_pkg::way_t'(w);
			end
		end
	end

	always_comb begin
		wr_way = victim_way;
		for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
			if (wr_match[w]) begin
				wr_way = cache_pkg::way_t'(w);	// Rewrite of a resident line
			end
		end
	end

	// Free-running while the consumer takes results
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer <= '0;
		end else if (!rd_stall) begin
			age_timer <= age_timer + 1'b1;
		end
	end

	assign age_tick   = (&age_timer) && !rd_stall && !wr_req;	// Dropped on write cycles
	assign rd_refresh = rd_accept && lookup.hit;

	// Flush, then write, then read refresh, then aging
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
				for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
					status[w][s] <= cache_pkg::STATUS_INVALID;
				end
			end
		end else if (flush) begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
				for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
					status[w][s] <= cache_pkg::STATUS_INVALID;
				end
			end
		end else begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
				for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
					if (wr_req && wr_way == cache_pkg::way_t'(w)
						&& wr.addr.index == cache_pkg::set_idx_t'(s)) begin
						status[w][s] <= cache_pkg::STATUS_NEWEST;
					end else if (rd_refresh && lookup.way == cache_pkg::way_t'(w)
						&& rd_addr.index == cache_pkg::set_idx_t'(s)) begin
						status[w][s] <= cache_pkg::STATUS_NEWEST;
					end else if (age_tick && status[w][s] >= 2'd2) begin
						status[w][s] <= status[w][s] - 2'd1;	// 3 to 2, 2 to 1
					end
				end
			end
		end
	end

	// Tag follows the write into its way, validity lives in the status
	always_ff @(posedge iCLOCK) begin
		if (wr_req) begin
			tags[wr_way][wr.addr.index] <= wr.addr.tag;
		end
	end

endmodule

// File: src/read_stage.sv
// Read result register with back-pressure hold and valid/hit qualification
`timescale 1ns/100ps

module read_stage (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 flush,
	input  logic                 rd_stall,
	input  logic                 rd_accept,
	input  cache_pkg::lookup_t   lookup,
	input  cache_pkg::word_idx_t rd_word,
	input  cache_pkg::word_t     word,
	output cache_pkg::way_t      sel_way,
	output cache_pkg::word_idx_t sel_word,
	output logic                 rd_valid,
	output logic                 rd_hit,
	output cache_pkg::word_t     rd_data
);

	logic                 acc_q;	// A read is pending
	cache_pkg::lookup_t   lookup_q;
	cache_pkg::word_idx_t word_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			acc_q    <= 1'b0;
			lookup_q <= '0;
		end else begin
			if (flush) begin
				acc_q <= 1'b0;
			end else if (!rd_stall) begin
				acc_q <= rd_accept;
			end
			if (!rd_stall) begin
				lookup_q <= lookup;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!rd_stall) begin
			word_q <= rd_word;
		end
	end

	assign sel_way  = lookup_q.way;
	assign sel_word = word_q;

	// Result withheld while downstream is stalled
	assign rd_valid = acc_q && !rd_stall;
	assign rd_hit   = rd_valid && lookup_q.hit;
	assign rd_data  = rd_hit ? word : '0;	// Zero on a miss

endmodule

// File: src/data_array.sv
// Four way RAMs with way-steered writes and way/word selection of the read word
`timescale 1ns/100ps

module data_array (
	input  logic                 iCLOCK,
	input  logic                 wr_req,
	input  cache_pkg::wr_req_t   wr,
	input  cache_pkg::way_t      wr_way,
	input  logic                 rd_load,
	input  cache_pkg::set_idx_t  rd_set,
	input  cache_pkg::way_t      sel_way,
	input  cache_pkg::word_idx_t sel_word,
	output cache_pkg::word_t     word
);

	cache_pkg::line_t rd_lines [cache_pkg::NUM_WAYS];

	for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
		line_ram way_ram (
			.iCLOCK  (iCLOCK),
			.wr_en   (wr_req && wr_way == cache_pkg::way_t'(w)),	// One way per write
			.wr_set  (wr.addr.index),
			.wr_word (wr.addr.word),
			.wr_data (wr.data),
			.rd_load (rd_load),
			.rd_set  (rd_set),
			.rd_line (rd_lines[w])
		);
	end

	// Way and word come from the read stage registers
	assign word = rd_lines[sel_way][{sel_word, 6'd0} +: $bits(cache_pkg::word_t)];

endmodule

// File: src/line_ram.sv
// Data RAM of one way, 16 lines with a word write enable and a registered read set
`timescale 1ns/100ps

module line_ram (
	input  logic                 iCLOCK,
	input  logic                 wr_en,
	input  cache_pkg::set_idx_t  wr_set,
	input  cache_pkg::word_idx_t wr_word,
	input  cache_pkg::word_t     wr_data,
	input  logic                 rd_load,
	input  cache_pkg::set_idx_t  rd_set,
	output cache_pkg::line_t     rd_line
);

	cache_pkg::line_t    mem [cache_pkg::NUM_SETS];
	cache_pkg::set_idx_t rd_set_q;

	// Only the addressed word slot of the line changes
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_set][{wr_word, 6'd0} +: $bits(cache_pkg::word_t)] <= wr_data;
		end
	end

	// Read address held with the pending result
	always_ff @(posedge iCLOCK) begin
		if (rd_load) begin
			rd_set_q <= rd_set;
		end
	end

	assign rd_line = mem[rd_set_q];	// Asynchronous read behind the address register

endmodule

// File: src/cache_pkg.sv
// Cache geometry constants, address fields, status encoding and request/result structs
package cache_pkg;

	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;

	typedef logic [21:0] tag_t;
	typedef logic [3:0]  set_idx_t;
	typedef logic [2:0]  word_idx_t;	// 64-bit word within a 64-byte line
	typedef logic [1:0]  way_t;

	// 0 is an empty line, 1 to 3 are valid lines with rising recency
	typedef logic [1:0]  status_t;

	localparam status_t STATUS_INVALID = 2'd0;
	localparam status_t STATUS_NEWEST  = 2'd3;

	typedef logic [63:0]  word_t;
	typedef logic [511:0] line_t;	// Eight words, word 0 in the low bits

	// Tag 22 | set 4 | word 3 | byte 3
	typedef struct packed {
		tag_t      tag;
		set_idx_t  index;
		word_idx_t word;
		logic [2:0] offset;
	} cache_addr_t;

	typedef struct packed {
		cache_addr_t addr;
		word_t       data;
	} wr_req_t;

	// Result of the tag compare for one read address
	typedef struct packed {
		logic hit;
		way_t way;
	} lookup_t;

endpackage
